//--- compile.f
design/tcdm_pkg.sv
design/tcdm_req_ctrl.sv
design/tcdm_lrsc_monitor.sv
design/tcdm_amo_unit.sv
design/tcdm_resp_buffer.sv
design/tcdm_adapter.sv
tb/tb_tcdm_adapter.sv

//--- design/tcdm_adapter.sv
// front end of a single-port memory bank
// valid/ready core requests in, SRAM strobe out, atomics and LR/SC
// handled in front of the bank
module tcdm_adapter import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // core request
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  tcdm_req_t req_i,
  // core response
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  output data_t     resp_rdata_o,
  output meta_t     resp_meta_o,
  // bank port
  output logic      bank_req_o,
  output bank_req_t bank_o,
  input  data_t     bank_rdata_i
);

  logic  req_accept;
  logic  sc_success;
  logic  amo_busy;
  addr_t amo_addr;
  data_t amo_wdata;
  logic  rdata_push;
  logic  sc_active;
  logic  sc_result;

  // ----------------------------------------
  // input side
  // ----------------------------------------
  tcdm_req_ctrl i_req_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .req_accept_o   (req_accept),
    .resp_pending_i (resp_valid_o),
    .resp_ready_i   (resp_ready_i),
    .amo_busy_i     (amo_busy),
    .amo_addr_i     (amo_addr),
    .amo_wdata_i    (amo_wdata),
    .sc_success_i   (sc_success),
    .bank_req_o     (bank_req_o),
    .bank_o         (bank_o),
    .rdata_push_o   (rdata_push),
    .sc_active_o    (sc_active),
    .sc_result_o    (sc_result)
  );

  // ----------------------------------------
  // processing
  // ----------------------------------------
  tcdm_lrsc_monitor i_lrsc_monitor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_accept_i (req_accept),
    .req_i        (req_i),
    .sc_success_o (sc_success)
  );

  tcdm_amo_unit i_amo_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_accept_i (req_accept),
    .req_i        (req_i),
    .bank_rdata_i (bank_rdata_i),
    .amo_busy_o   (amo_busy),
    .amo_addr_o   (amo_addr),
    .amo_wdata_o  (amo_wdata)
  );

  // ----------------------------------------
  // output side
  // ----------------------------------------
  tcdm_resp_buffer i_resp_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_push_i  (req_accept),
    .meta_i       (req_i.meta),
    .rdata_push_i (rdata_push),
    .bank_rdata_i (bank_rdata_i),
    .sc_active_i  (sc_active),
    .sc_result_i  (sc_result),
    .resp_ready_i (resp_ready_i),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_meta_o  (resp_meta_o)
  );

endmodule

//--- design/tcdm_amo_unit.sv
// atomic read-modify-write unit
// latches the operand at acceptance, combines it with the old bank
// word one cycle later and hands the result to the write-back
module tcdm_amo_unit import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_accept_i,
  input  tcdm_req_t req_i,
  input  data_t     bank_rdata_i,
  output logic      amo_busy_o,
  output addr_t     amo_addr_o,
  output data_t     amo_wdata_o
);

  amo_state_e state_d, state_q;

  amo_op_t op_q;
  addr_t   addr_q;
  data_t   operand_q;

  logic load_amo;

  // ALU signals
  data_t              old_word;
  logic               cmp_signed;
  logic [DataWidth:0] cmp_a;
  logic [DataWidth:0] cmp_b;
  logic [DataWidth:0] cmp_diff;
  logic               old_lt_operand;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  // LR and SC go through the reservation path, not here
  assign load_amo = req_accept_i &&
                    (req_i.amo inside {AmoSwap, AmoAdd, AmoAnd, AmoOr, AmoXor,
                                       AmoMax, AmoMaxu, AmoMin, AmoMinu});

  always_comb begin
    state_d = state_q;
    case (state_q)
      AmoIdle: begin
        if (load_amo) begin
          state_d = AmoWriteBack;
        end
      end
      // single write-back cycle, then release the port
      AmoWriteBack: state_d = AmoIdle;
      default:      state_d = AmoIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AmoIdle;
      op_q    <= AmoNone;
    end else begin
      state_q <= state_d;
      if (load_amo) begin
        op_q <= req_i.amo;
      end
    end
  end

  // address and operand
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q    <= req_i.addr;
      operand_q <= req_i.wdata;
    end
  end

  assign amo_busy_o = (state_q == AmoWriteBack);
  assign amo_addr_o = addr_q;

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  // the bank returns the old word in the write-back cycle
  assign old_word = bank_rdata_i;

  // one 33-bit subtract serves all four compares
  // sign or zero extension picks signed vs unsigned
  assign cmp_signed     = (op_q == AmoMax) || (op_q == AmoMin);
  assign cmp_a          = {cmp_signed & old_word[DataWidth-1], old_word};
  assign cmp_b          = {cmp_signed & operand_q[DataWidth-1], operand_q};
  assign cmp_diff       = cmp_a - cmp_b;
  assign old_lt_operand = cmp_diff[DataWidth];

  always_comb begin
    // swap just writes the operand
    amo_wdata_o = operand_q;
    case (op_q)
      AmoAdd: amo_wdata_o = old_word + operand_q;
      AmoAnd: amo_wdata_o = old_word & operand_q;
      AmoOr:  amo_wdata_o = old_word | operand_q;
      AmoXor: amo_wdata_o = old_word ^ operand_q;
      AmoMax, AmoMaxu: begin
        amo_wdata_o = old_lt_operand ? operand_q : old_word;
      end
      AmoMin, AmoMinu: begin
        amo_wdata_o = old_lt_operand ? old_word : operand_q;
      end
      default: amo_wdata_o = operand_q;
    endcase
  end

endmodule

//--- design/tcdm_lrsc_monitor.sv
// LR/SC reservation tracker
// holds one reservation keyed on the requesting core and address
module tcdm_lrsc_monitor import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_accept_i,
  input  tcdm_req_t req_i,
  output logic      sc_success_o
);

  typedef struct packed {
    logic     valid;
    addr_t    addr;
    core_id_t core;
  } reservation_t;

  reservation_t res_d, res_q;

  logic same_core;
  logic same_addr;
  logic breaks_res;

  assign same_core = (res_q.core == req_i.meta.core_id);
  assign same_addr = (res_q.addr == req_i.addr);

  // stores and read-modify-write atomics kill a matching reservation
  assign breaks_res = (req_i.write && (req_i.amo == AmoNone)) ||
                      !(req_i.amo inside {AmoNone, AmoLr, AmoSc});

  always_comb begin
    res_d        = res_q;
    sc_success_o = 1'b0;

    if (req_accept_i) begin
      // LR reserves, unless another core already holds a live one
      // the owner may move its own reservation
      if (req_i.amo == AmoLr && (!res_q.valid || same_core)) begin
        res_d.valid = 1'b1;
        res_d.addr  = req_i.addr;
        res_d.core  = req_i.meta.core_id;
      end

      if (same_addr && breaks_res) begin
        res_d.valid = 1'b0;
      end

      // any SC of the owner ends the reservation
      if (req_i.amo == AmoSc && res_q.valid && same_core) begin
        res_d.valid  = 1'b0;
        sc_success_o = same_addr;
      end
    end
  end

  // reservation register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_q <= '0;
    end else begin
      res_q <= res_d;
    end
  end

endmodule

//--- design/tcdm_pkg.sv
// shared types for the memory bank front end
// widths, request and bank structs, atomic opcodes and FSM states
package tcdm_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  // word address into the bank
  localparam int unsigned AddrWidth   = 10;
  // the atomic ALU is built for 32-bit words only
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;
  // up to 16 requesting cores
  localparam int unsigned CoreIdWidth = 4;
  // requester transaction id, echoed with the response
  localparam int unsigned TagWidth    = 4;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [BeWidth-1:0]     be_t;
  typedef logic [CoreIdWidth-1:0] core_id_t;
  typedef logic [TagWidth-1:0]    tag_t;

  // ----------------------------------------
  // opcodes and states
  // ----------------------------------------
  // same encoding as the core side atomic field
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9,
    AmoLr   = 4'hA,
    AmoSc   = 4'hB
  } amo_op_t;

  // read in the accept cycle, write-back in the next one
  typedef enum logic [1:0] {
    AmoIdle,
    AmoWriteBack
  } amo_state_e;

  // ----------------------------------------
  // structs
  // ----------------------------------------
  // requester info, returned untouched with the response
  typedef struct packed {
    core_id_t core_id;
    tag_t     tag;
  } meta_t;

  typedef struct packed {
    addr_t   addr;
    amo_op_t amo;
    logic    write;
    data_t   wdata;
    be_t     be;
    meta_t   meta;
  } tcdm_req_t;

  // bank side, the strobe travels separately
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
    be_t   be;
  } bank_req_t;

endpackage

//--- design/tcdm_req_ctrl.sv
// request side of the bank front end
// accepts core requests and drives the SRAM port from either the
// core or the AMO write-back, then marks which accesses return data
module tcdm_req_ctrl import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // core request
  input  logic      req_valid_i,
  input  tcdm_req_t req_i,
  output logic      req_ready_o,
  output logic      req_accept_o,
  // response side status
  input  logic      resp_pending_i,
  input  logic      resp_ready_i,
  // atomic unit
  input  logic      amo_busy_i,
  input  addr_t     amo_addr_i,
  input  data_t     amo_wdata_i,
  // reservation check
  input  logic      sc_success_i,
  // bank port
  output logic      bank_req_o,
  output bank_req_t bank_o,
  // towards the response buffer
  output logic      rdata_push_o,
  output logic      sc_active_o,
  output logic      sc_result_o
);

  logic is_sc;
  logic is_store;
  logic sc_accept;

  assign is_sc    = (req_i.amo == AmoSc);
  assign is_store = req_i.write && (req_i.amo == AmoNone);

  // stall during write-back, and while a response sits unclaimed
  assign req_ready_o  = !amo_busy_i && !(resp_pending_i && !resp_ready_i);
  assign req_accept_o = req_valid_i && req_ready_o;
  assign sc_accept    = req_accept_o && is_sc;

  // ----------------------------------------
  // bank port mux
  // ----------------------------------------
  always_comb begin
    if (amo_busy_i) begin
      // the write-back owns the port for its one cycle
      bank_req_o   = 1'b1;
      bank_o.addr  = amo_addr_i;
      bank_o.write = 1'b1;
      bank_o.wdata = amo_wdata_i;
      bank_o.be    = '1;
    end else begin
      bank_req_o   = req_accept_o;
      bank_o.addr  = req_i.addr;
      // a failed SC degrades to a read whose data is dropped
      bank_o.write = is_sc ? sc_success_i : is_store;
      bank_o.wdata = req_i.wdata;
      bank_o.be    = req_i.be;
    end
  end

  // ----------------------------------------
  // response bookkeeping
  // ----------------------------------------
  // data valid one cycle after a read, SC result follows the same slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_push_o <= 1'b0;
      sc_active_o  <= 1'b0;
    end else begin
      rdata_push_o <= (bank_req_o && !bank_o.write) || sc_accept;
      sc_active_o  <= sc_accept;
    end
  end

  // 0 reports success, 1 failure
  always_ff @(posedge clk_i) begin
    sc_result_o <= !sc_success_i;
  end

endmodule

//--- design/tcdm_resp_buffer.sv
// response buffer of the bank front end
// pairs the requester metadata with the bank word or the SC result
// and holds the pair under back-pressure
module tcdm_resp_buffer import tcdm_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // metadata, captured at acceptance
  input  logic  meta_push_i,
  input  meta_t meta_i,
  // data, one cycle after the bank access
  input  logic  rdata_push_i,
  input  data_t bank_rdata_i,
  input  logic  sc_active_i,
  input  logic  sc_result_i,
  // core response
  input  logic  resp_ready_i,
  output logic  resp_valid_o,
  output data_t resp_rdata_o,
  output meta_t resp_meta_o
);

  logic  meta_valid_q;
  meta_t meta_q;

  logic  data_valid_q;
  logic  data_valid;
  data_t data_q;
  data_t data_in;

  logic  pop;

  // response only once both halves are there, data always comes last
  assign resp_valid_o = meta_valid_q && data_valid;
  assign pop          = resp_valid_o && resp_ready_i;

  // ----------------------------------------
  // metadata register
  // ----------------------------------------
  // every accepted request writes here
  // a store entry gets no data and is replaced by the next push
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_valid_q <= 1'b0;
    end else begin
      meta_valid_q <= meta_push_i || (meta_valid_q && !pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_q <= meta_i;
    end
  end

  assign resp_meta_o = meta_q;

  // ----------------------------------------
  // data register, fall-through
  // ----------------------------------------
  // SC answers with its status bit instead of the bank word
  assign data_in = sc_active_i ? {{(DataWidth-1){1'b0}}, sc_result_i} : bank_rdata_i;

  assign data_valid   = data_valid_q || rdata_push_i;
  assign resp_rdata_o = data_valid_q ? data_q : data_in;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_valid_q <= 1'b0;
    end else if (data_valid_q) begin
      data_valid_q <= !pop || rdata_push_i;
    end else begin
      // store only what is not taken right away
      data_valid_q <= rdata_push_i && !pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_push_i) begin
      data_q <= data_in;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the bank front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_tcdm_adapter \
  --Mdir obj_dir -o sim_tcdm_adapter
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_tcdm_adapter 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

//--- tb/tb_tcdm_adapter.sv
// testbench for the memory bank front end
// directed and random traffic against a bank model and a reference memory
module tb_tcdm_adapter import tcdm_pkg::*; ();

  localparam int unsigned NumRandomOps  = 200;
  // directed part plus a generous per-op budget for random back-pressure
  localparam int unsigned TimeoutCycles = 1000 + NumRandomOps * 15;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      req_valid_i;
  logic      req_ready_o;
  tcdm_req_t req_i;
  logic      resp_valid_o;
  logic      resp_ready_i;
  data_t     resp_rdata_o;
  meta_t     resp_meta_o;
  logic      bank_req_o;
  bank_req_t bank_o;
  data_t     bank_rdata_i = '0;

  // bank contents and the expected contents
  data_t    bank_mem [1024];
  data_t    ref_mem  [1024];
  // expected reservation
  logic     res_valid;
  addr_t    res_addr;
  core_id_t res_core;
  tag_t     tag_cnt;
  // random resp_ready_i while set
  logic     bp_on;

  always #20 clk_i = ~clk_i;

  tcdm_adapter DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .resp_meta_o  (resp_meta_o),
    .bank_req_o   (bank_req_o),
    .bank_o       (bank_o),
    .bank_rdata_i (bank_rdata_i)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // every address bit shows up in the word
  function automatic data_t fill_word(input int a);
    addr_t w;
    w = addr_t'(a);
    return {w, ~w, w, 2'b01};
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
    data_t res;
    res = old;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // expected new word of a read-modify-write atomic
  function automatic data_t amo_result(input amo_op_t op, input data_t a, input data_t b);
    case (op)
      AmoAdd:  return a + b;
      AmoAnd:  return a & b;
      AmoOr:   return a | b;
      AmoXor:  return a ^ b;
      AmoMax:  return ($signed(a) > $signed(b)) ? a : b;
      AmoMaxu: return (a > b) ? a : b;
      AmoMin:  return ($signed(a) < $signed(b)) ? a : b;
      AmoMinu: return (a < b) ? a : b;
      default: return b;
    endcase
  endfunction

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_meta(input string name, input meta_t exp, input meta_t act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------
  // bank model
  // ----------------------------------------
  // synchronous SRAM that holds its read data during writes
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < 1024; i++) begin
        bank_mem[i] = fill_word(i);
      end
    end else if (bank_req_o) begin
      if (bank_o.write) begin
        bank_mem[bank_o.addr] = merge_bytes(bank_mem[bank_o.addr], bank_o.wdata, bank_o.be);
      end else begin
        bank_rdata_i <= bank_mem[bank_o.addr];
      end
    end
  end

  // ----------------------------------------
  // request and response
  // ----------------------------------------
  // returns on the edge that accepts the request
  task automatic send_req(input tcdm_req_t r);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= r;
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  // checks the response in every cycle it is shown until it is taken
  task automatic wait_resp(input data_t exp_data, input meta_t exp_meta);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      if (resp_valid_o) begin
        check_data("resp_rdata_o", exp_data, resp_rdata_o);
        check_meta("resp_meta_o", exp_meta, resp_meta_o);
        taken = resp_ready_i;
      end
      @(posedge clk_i);
      resp_ready_i <= bp_on ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  endtask

  // updates the reference model, issues one request and checks its answer
  task automatic do_op(input amo_op_t op, input logic wr, input addr_t addr,
                       input data_t wdata, input be_t be, input core_id_t core);
    tcdm_req_t r;
    data_t     old;
    data_t     exp;
    logic      has_resp;
    logic      owner;
    logic      sc_ok;
    old      = ref_mem[addr];
    exp      = old;
    has_resp = 1'b1;
    owner    = res_valid && (res_core == core);
    sc_ok    = owner && (res_addr == addr);
    case (op)
      AmoNone: begin
        if (wr) begin
          ref_mem[addr] = merge_bytes(old, wdata, be);
          has_resp      = 1'b0;
          if (res_addr == addr) begin
            res_valid = 1'b0;
          end
        end
      end
      AmoLr: begin
        // another core's live reservation is kept
        if (!res_valid || owner) begin
          res_valid = 1'b1;
          res_addr  = addr;
          res_core  = core;
        end
      end
      AmoSc: begin
        exp = sc_ok ? '0 : data_t'(1);
        if (sc_ok) begin
          ref_mem[addr] = merge_bytes(old, wdata, be);
        end
        if (owner) begin
          res_valid = 1'b0;
        end
      end
      default: begin
        ref_mem[addr] = amo_result(op, old, wdata);
        if (res_addr == addr) begin
          res_valid = 1'b0;
        end
      end
    endcase
    r.addr         = addr;
    r.amo          = op;
    r.write        = wr;
    r.wdata        = wdata;
    r.be           = be;
    r.meta.core_id = core;
    r.meta.tag     = tag_cnt;
    tag_cnt        = tag_cnt + 4'd1;
    send_req(r);
    if (has_resp) begin
      wait_resp(exp, r.meta);
    end else begin
      // a store answers nothing
      @(negedge clk_i);
      check_bit("resp_valid_o", 1'b0, resp_valid_o);
    end
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic store_then_load();
    @(negedge clk_i);
    check_bit("resp_valid_o", 1'b0, resp_valid_o);
    check_bit("bank_req_o", 1'b0, bank_req_o);
    // bytes 0 and 2 only
    do_op(AmoNone, 1'b1, 10'd7, 32'hdead_beef, 4'b0101, 4'd3);
    do_op(AmoNone, 1'b0, 10'd7, '0, 4'hf, 4'd3);
  endtask

  task automatic atomic_corners();
    data_t olds  [3];
    data_t opnds [3];
    addr_t a;
    // sign bit set against max positive, negative vs positive, equal
    olds[0]  = 32'h8000_0000;
    opnds[0] = 32'h7fff_ffff;
    olds[1]  = 32'hffff_fffe;
    opnds[1] = 32'h0000_0003;
    olds[2]  = 32'h0000_0005;
    opnds[2] = 32'h0000_0005;
    for (int p = 0; p < 3; p++) begin
      for (int o = 1; o <= 9; o++) begin
        a = addr_t'(100 + o);
        do_op(AmoNone, 1'b1, a, olds[p], 4'hf, 4'd2);
        do_op(amo_op_t'(o[3:0]), 1'b0, a, opnds[p], 4'hf, 4'd2);
        do_op(AmoNone, 1'b0, a, '0, 4'hf, 4'd2);
      end
    end
  endtask

  task automatic lrsc_same_core();
    do_op(AmoLr, 1'b0, 10'd20, '0, 4'hf, 4'd1);
    do_op(AmoSc, 1'b1, 10'd20, 32'h1234_5678, 4'hf, 4'd1);
    do_op(AmoNone, 1'b0, 10'd20, '0, 4'hf, 4'd1);
    // reservation is gone now
    do_op(AmoSc, 1'b1, 10'd21, 32'h0000_cafe, 4'hf, 4'd1);
    do_op(AmoNone, 1'b0, 10'd21, '0, 4'hf, 4'd1);
  endtask

  task automatic lrsc_other_core();
    do_op(AmoLr, 1'b0, 10'd30, '0, 4'hf, 4'd2);
    do_op(AmoNone, 1'b1, 10'd30, 32'h5555_aaaa, 4'hf, 4'd3);
    do_op(AmoSc, 1'b1, 10'd30, 32'h0f0f_0f0f, 4'hf, 4'd2);
    // core 3 cannot steal the reservation of core 2
    do_op(AmoLr, 1'b0, 10'd40, '0, 4'hf, 4'd2);
    do_op(AmoLr, 1'b0, 10'd40, '0, 4'hf, 4'd3);
    do_op(AmoSc, 1'b1, 10'd40, 32'h3333_3333, 4'hf, 4'd3);
    do_op(AmoSc, 1'b1, 10'd40, 32'h2222_2222, 4'hf, 4'd2);
    do_op(AmoNone, 1'b0, 10'd40, '0, 4'hf, 4'd2);
  endtask

  task automatic backpressure_hold();
    tcdm_req_t r;
    data_t     exp;
    do_op(AmoNone, 1'b1, 10'd50, 32'h0bad_f00d, 4'hf, 4'd5);
    exp            = ref_mem[50];
    r              = '0;
    r.addr         = 10'd50;
    r.amo          = AmoNone;
    r.be           = 4'hf;
    r.meta.core_id = 4'd5;
    r.meta.tag     = tag_cnt;
    tag_cnt        = tag_cnt + 4'd1;
    @(posedge clk_i);
    resp_ready_i <= 1'b0;
    send_req(r);
    // response holds and requests stall
    repeat (6) begin
      @(negedge clk_i);
      check_bit("resp_valid_o", 1'b1, resp_valid_o);
      check_data("resp_rdata_o", exp, resp_rdata_o);
      check_meta("resp_meta_o", r.meta, resp_meta_o);
      check_bit("req_ready_o", 1'b0, req_ready_o);
    end
    @(posedge clk_i);
    resp_ready_i <= 1'b1;
    @(negedge clk_i);
    check_bit("resp_valid_o", 1'b1, resp_valid_o);
    check_bit("req_ready_o", 1'b1, req_ready_o);
    // taken exactly once
    @(negedge clk_i);
    check_bit("resp_valid_o", 1'b0, resp_valid_o);
    do_op(AmoNone, 1'b0, 10'd51, '0, 4'hf, 4'd5);
  endtask

  task automatic random_traffic();
    amo_op_t op;
    logic    wr;
    bp_on = 1'b1;
    for (int n = 0; n < NumRandomOps; n++) begin
      op = amo_op_t'($urandom_range(0, 11));
      wr = (op == AmoSc) || ((op == AmoNone) && 1'($urandom_range(0, 1)));
      // few addresses and cores so reservations collide
      do_op(op, wr, addr_t'($urandom_range(0, 15)), data_t'($urandom()),
            be_t'($urandom_range(1, 15)), core_id_t'($urandom_range(0, 3)));
    end
    bp_on = 1'b0;
    @(posedge clk_i);
    resp_ready_i <= 1'b1;
  endtask

  // ----------------------------------------
  // main sequence and watchdog
  // ----------------------------------------
  initial begin
    void'($urandom(32'h8cd2));
    rst_ni       <= 1'b0;
    req_valid_i  <= 1'b0;
    req_i        <= '0;
    resp_ready_i <= 1'b1;
    bp_on     = 1'b0;
    tag_cnt   = '0;
    res_valid = 1'b0;
    res_addr  = '0;
    res_core  = '0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_word(i);
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    store_then_load();
    atomic_corners();
    lrsc_same_core();
    lrsc_other_core();
    backpressure_hold();
    random_traffic();

    $display("=== PASS ===");
    $finish;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    abort_run();
  end

endmodule
